//--- source/parking_settings.svh
`ifndef PARKING_SETTINGS_SVH
`define PARKING_SETTINGS_SVH

// Tower geometry and order queue
`define PLATE_W         16
`define FLOORS          7       // Parking floors, floor 0 is the entrance
`define QUEUE_DEPTH     4       // Also the host's initial credits

// Plate prefixes in the top nibble
`define HANDICAP_NIBBLE 9
`define HYBRID_NIBBLE   8

// Fee added per billing tick
`define RATE_HANDICAP   0
`define RATE_HYBRID     1
`define RATE_OTHER      2
`define FEE_MAX         255

`endif

//--- source/parking_pkg.sv
`default_nettype none

`include "parking_settings.svh"

package parking_pkg;

    typedef logic [`PLATE_W-1:0] plate_t;   // Zero marks an empty spot

    typedef enum logic {
        order_park,
        order_retrieve
    } order_kind_t;

    typedef struct packed {
        order_kind_t kind;
        plate_t      plate;
    } order_t;

    // Outcome reported to the host
    typedef enum logic [1:0] {
        event_parked,
        event_departed,
        event_refused
    } event_kind_t;

    typedef logic [$clog2(`FEE_MAX + 1)-1:0] fee_t;

endpackage

`default_nettype wire

//--- source/lot_pkg.sv
`default_nettype none

`include "parking_settings.svh"

package lot_pkg;

    localparam int spot_count = 2 * `FLOORS;

    typedef logic [$clog2(`FLOORS + 1)-1:0] floor_t;
    typedef enum logic {side_left, side_right} side_t;

    typedef struct packed {
        floor_t floor;
        side_t  side;
    } spot_t;

    typedef logic [$clog2(spot_count)-1:0] spot_idx_t;

    // Spots are numbered floor by floor from floor 1, left before right
    function automatic spot_idx_t spot_index(spot_t spot);
        return spot_idx_t'({spot.floor - floor_t'(1), spot.side});
    endfunction

    function automatic spot_t spot_at(int idx);
        spot_t spot;
        spot.floor = floor_t'(idx / 2 + 1);
        spot.side  = side_t'(idx % 2);
        return spot;
    endfunction

endpackage

`default_nettype wire

//--- source/parking_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// Queue head towards the elevator controller
interface order_if;
    logic                avail;     // At least one order waiting
    parking_pkg::order_t head;      // Oldest order, valid while avail
    logic                take;      // Pops the head at the next edge

    modport source (output avail, head, input take);
    modport sink (input avail, head, output take);
endinterface

// Spot lookups and the single spot write
interface slot_if;
    parking_pkg::plate_t find_plate;
    logic                free_found;
    lot_pkg::spot_t      free_spot;
    logic                hit;
    lot_pkg::spot_t      hit_spot;
    logic                wr_en;
    lot_pkg::spot_t      wr_spot;
    parking_pkg::plate_t wr_plate;  // Zero frees the spot

    modport ctrl (
        output find_plate, wr_en, wr_spot, wr_plate,
        input  free_found, free_spot, hit, hit_spot
    );
    modport store (
        input  find_plate, wr_en, wr_spot, wr_plate,
        output free_found, free_spot, hit, hit_spot
    );
    modport meter (input wr_en, wr_spot, wr_plate);
endinterface

`default_nettype wire

//--- source/order_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "parking_settings.svh"

module order_queue (
    input  logic                clock,
    input  logic                reset,
    input  logic                push_valid,
    input  parking_pkg::order_t push_order,
    output logic                credit,
    order_if.source             orders
);

    localparam int depth = `QUEUE_DEPTH;
    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    parking_pkg::order_t entries [depth];
    logic [ptr_w-1:0]    head_ptr;
    logic [ptr_w-1:0]    tail_ptr;
    logic [cnt_w-1:0]    count;

    function automatic logic [ptr_w-1:0] next_ptr(logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Host only pushes with a credit in hand, so no full check here
    always_ff @(posedge clock) begin
        if (push_valid) begin
            entries[tail_ptr] <= push_order;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
            credit   <= 1'b0;
        end else begin
            if (push_valid) begin
                tail_ptr <= next_ptr(tail_ptr);
            end
            if (orders.take) begin
                head_ptr <= next_ptr(head_ptr);
            end
            case ({push_valid, orders.take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // Idle or push and pop together
            endcase
            credit <= orders.take;           // Entry freed, hand one credit back
        end
    end

    assign orders.avail = (count != '0);
    assign orders.head  = entries[head_ptr];

endmodule

`default_nettype wire

//--- source/slot_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "parking_settings.svh"

module slot_store (
    input  logic  clock,
    input  logic  reset,
    slot_if.store slots
);

    localparam int reserved_top = 2;    // Floors whose left spot is handicapped only

    parking_pkg::plate_t plates [lot_pkg::spot_count];

    logic is_suv;
    logic is_handicap;

    assign is_suv      = slots.find_plate[0];   // Odd plates go to odd floors
    assign is_handicap = (slots.find_plate[`PLATE_W-1 -: 4] == 4'(`HANDICAP_NIBBLE));

    // Free spot search, first hit in index order wins
    always_comb begin
        lot_pkg::spot_t spot;
        logic           allowed;
        slots.free_found = 1'b0;
        slots.free_spot  = '0;
        for (int i = 0; i < lot_pkg::spot_count; i++) begin
            spot    = lot_pkg::spot_at(i);
            allowed = (spot.floor[0] == is_suv);
            if (spot.side == lot_pkg::side_left &&
                spot.floor <= lot_pkg::floor_t'(reserved_top)) begin
                allowed = allowed && is_handicap;
            end
            if (!slots.free_found && allowed && plates[i] == '0) begin
                slots.free_found = 1'b1;
                slots.free_spot  = spot;
            end
        end
    end

    // Plate match over all spots
    always_comb begin
        slots.hit      = 1'b0;
        slots.hit_spot = '0;
        for (int i = 0; i < lot_pkg::spot_count; i++) begin
            if (slots.find_plate != '0 && plates[i] == slots.find_plate) begin
                slots.hit      = 1'b1;
                slots.hit_spot = lot_pkg::spot_at(i);
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < lot_pkg::spot_count; i++) begin
                plates[i] <= '0;     // All spots empty
            end
        end else if (slots.wr_en) begin
            plates[lot_pkg::spot_index(slots.wr_spot)] <= slots.wr_plate;
        end
    end

endmodule

`default_nettype wire

//--- source/fee_meter.sv
`timescale 1ns/1ps
`default_nettype none

`include "parking_settings.svh"

module fee_meter (
    input  logic              clock,
    input  logic              reset,
    input  logic              tick,
    slot_if.meter             slots,
    input  lot_pkg::spot_t    query_spot,
    output parking_pkg::fee_t fee
);

    parking_pkg::fee_t              acc [lot_pkg::spot_count];
    logic [1:0]                     rate [lot_pkg::spot_count];
    logic [lot_pkg::spot_count-1:0] occupied;
    lot_pkg::spot_idx_t             wr_idx;

    function automatic logic [1:0] rate_of(parking_pkg::plate_t plate);
        logic [3:0] nibble;
        nibble = plate[`PLATE_W-1 -: 4];
        if (nibble == 4'(`HANDICAP_NIBBLE)) return 2'(`RATE_HANDICAP);
        if (nibble == 4'(`HYBRID_NIBBLE)) return 2'(`RATE_HYBRID);
        return 2'(`RATE_OTHER);
    endfunction

    function automatic parking_pkg::fee_t add_sat(parking_pkg::fee_t base, logic [1:0] step);
        logic [$bits(parking_pkg::fee_t):0] sum;
        sum = base + step;
        return (sum > `FEE_MAX) ? parking_pkg::fee_t'(`FEE_MAX) : sum[$bits(parking_pkg::fee_t)-1:0];
    endfunction

    assign wr_idx = lot_pkg::spot_index(slots.wr_spot);

    always_ff @(posedge clock) begin
        if (slots.wr_en) begin
            rate[wr_idx] <= rate_of(slots.wr_plate);  // Classified when the car arrives
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            occupied <= '0;
            for (int i = 0; i < lot_pkg::spot_count; i++) begin
                acc[i] <= '0;
            end
        end else begin
            for (int i = 0; i < lot_pkg::spot_count; i++) begin
                if (slots.wr_en && wr_idx == i) begin
                    acc[i]      <= '0;
                    occupied[i] <= (slots.wr_plate != '0);
                end else if (tick && occupied[i]) begin
                    acc[i] <= add_sat(acc[i], rate[i]);
                end
            end
        end
    end

    assign fee = acc[lot_pkg::spot_index(query_spot)];

endmodule

`default_nettype wire

//--- source/elevator_controller.sv
`timescale 1ns/1ps
`default_nettype none

module elevator_controller (
    input  logic                     clock,
    input  logic                     reset,
    order_if.sink                    orders,
    slot_if.ctrl                     slots,
    input  parking_pkg::fee_t        fee,
    output lot_pkg::spot_t           query_spot,
    output lot_pkg::floor_t          current_floor,
    output logic                     event_valid,
    output parking_pkg::event_kind_t event_kind,
    output parking_pkg::plate_t      event_plate,
    output lot_pkg::spot_t           event_spot,
    output parking_pkg::fee_t        event_fee
);

    typedef enum logic [2:0] {
        st_idle,
        st_decide,
        st_ascend,
        st_store,
        st_descend
    } state_t;

    state_t              state;
    parking_pkg::order_t order_q;   // Order being served
    lot_pkg::spot_t      target;    // Spot to fill or empty
    logic                is_park;
    logic                accept;

    assign is_park = (order_q.kind == parking_pkg::order_park);
    assign accept  = is_park ? slots.free_found : slots.hit;

    assign orders.take      = (state == st_idle) && orders.avail;
    assign slots.find_plate = order_q.plate;
    assign slots.wr_en      = (state == st_store);
    assign slots.wr_spot    = target;
    assign slots.wr_plate   = is_park ? order_q.plate : '0;  // Retrieve empties the spot
    assign query_spot       = target;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state         <= st_idle;
            current_floor <= '0;
            event_valid   <= 1'b0;
        end else begin
            event_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (orders.avail) begin
                        state <= st_decide;
                    end
                end
                st_decide: begin
                    if (accept) begin
                        state <= st_ascend;
                    end else begin
                        state       <= st_idle;      // Refused, elevator never leaves floor 0
                        event_valid <= 1'b1;
                    end
                end
                st_ascend: begin
                    current_floor <= current_floor + 1'b1;
                    if (lot_pkg::floor_t'(current_floor + 1'b1) == target.floor) begin
                        state <= st_store;
                    end
                end
                st_store: begin
                    event_valid <= 1'b1;
                    state       <= st_descend;
                end
                st_descend: begin
                    current_floor <= current_floor - 1'b1;
                    if (current_floor == lot_pkg::floor_t'(1)) begin
                        state <= st_idle;            // Back at the entrance
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Order latch and event payload
    always_ff @(posedge clock) begin
        if (orders.take) begin
            order_q <= orders.head;
        end
        if (state == st_decide) begin
            target <= is_park ? slots.free_spot : slots.hit_spot;
            if (!accept) begin
                event_kind  <= parking_pkg::event_refused;
                event_plate <= order_q.plate;
                event_spot  <= '0;
                event_fee   <= '0;
            end
        end
        if (state == st_store) begin
            if (is_park) begin
                event_kind <= parking_pkg::event_parked;
                event_fee  <= '0;
            end else begin
                event_kind <= parking_pkg::event_departed;
                event_fee  <= fee;                   // Read before the write clears it
            end
            event_plate <= order_q.plate;
            event_spot  <= target;
        end
    end

endmodule

`default_nettype wire

//--- source/parking_top.sv
`timescale 1ns/1ps
`default_nettype none

module parking_top (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     tick,
    input  logic                     order_valid,
    input  parking_pkg::order_kind_t order_kind,
    input  parking_pkg::plate_t      order_plate,
    output logic                     order_credit,
    output logic                     event_valid,
    output parking_pkg::event_kind_t event_kind,
    output parking_pkg::plate_t      event_plate,
    output lot_pkg::spot_t           event_spot,
    output parking_pkg::fee_t        event_fee,
    output lot_pkg::floor_t          current_floor
);

    order_if order_bus ();
    slot_if  slot_bus ();

    parking_pkg::order_t push_order;
    parking_pkg::fee_t   fee;           // Fee of the queried spot
    lot_pkg::spot_t      query_spot;

    assign push_order = '{kind: order_kind, plate: order_plate};

    order_queue u_queue (
        .clock      (clock),
        .reset      (reset),
        .push_valid (order_valid),
        .push_order (push_order),
        .credit     (order_credit),
        .orders     (order_bus.source)
    );

    slot_store u_store (
        .clock (clock),
        .reset (reset),
        .slots (slot_bus.store)
    );

    fee_meter u_meter (
        .clock      (clock),
        .reset      (reset),
        .tick       (tick),
        .slots      (slot_bus.meter),
        .query_spot (query_spot),
        .fee        (fee)
    );

    elevator_controller u_ctrl (
        .clock         (clock),
        .reset         (reset),
        .orders        (order_bus.sink),
        .slots         (slot_bus.ctrl),
        .fee           (fee),
        .query_spot    (query_spot),
        .current_floor (current_floor),
        .event_valid   (event_valid),
        .event_kind    (event_kind),
        .event_plate   (event_plate),
        .event_spot    (event_spot),
        .event_fee     (event_fee)
    );

endmodule

`default_nettype wire

//--- tb/parking_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "parking_settings.svh"

module parking_assertions (
    input logic            clock,
    input logic            reset,
    input logic            order_valid,
    input logic            order_credit,
    input logic            event_valid,
    input lot_pkg::floor_t current_floor
);

    // Orders pushed and not yet credited back, never less than the queue fill
    int outstanding;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(order_valid) - int'(order_credit);
        end
    end

    event_single_pulse: assert property (@(posedge clock) disable iff (reset)
        event_valid |=> !event_valid)
        else $error("event_valid stayed high for more than one cycle");

    credit_single_pulse: assert property (@(posedge clock) disable iff (reset)
        order_credit |=> !order_credit)
        else $error("order_credit stayed high for more than one cycle");

    floor_step: assert property (@(posedge clock) disable iff (reset)
        (current_floor == $past(current_floor)) ||
        (current_floor == lot_pkg::floor_t'($past(current_floor) + 1'b1)) ||
        ($past(current_floor) == lot_pkg::floor_t'(current_floor + 1'b1)))
        else $error("current_floor moved by more than one floor in a cycle");

    no_push_when_full: assert property (@(posedge clock) disable iff (reset)
        order_valid |-> (outstanding < `QUEUE_DEPTH))
        else $error("order pushed while the order queue was full");

endmodule

`default_nettype wire

//--- tb/parking_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "parking_settings.svh"

module parking_tb;

    typedef struct packed {
        parking_pkg::event_kind_t kind;
        parking_pkg::plate_t      plate;
        lot_pkg::spot_t           spot;
        parking_pkg::fee_t        fee;
    } expected_t;

    localparam int max_orders  = 64;
    localparam int tick_cycles = 2 * (7 + 130);     // Two cycles per tick over both stays
    localparam int cycle_limit = max_orders * 20 + tick_cycles + 200;

    logic                     clock = 1'b0;
    logic                     reset = 1'b1;
    logic                     tick = 1'b0;
    logic                     order_valid = 1'b0;
    parking_pkg::order_kind_t order_kind = parking_pkg::order_park;
    parking_pkg::plate_t      order_plate = '0;
    logic                     order_credit;
    logic                     event_valid;
    parking_pkg::event_kind_t event_kind;
    parking_pkg::plate_t      event_plate;
    lot_pkg::spot_t           event_spot;
    parking_pkg::fee_t        event_fee;
    lot_pkg::floor_t          current_floor;

    // Reference model of the tower
    parking_pkg::plate_t lot_plate [1:`FLOORS][2];
    int                  lot_fee [1:`FLOORS][2];
    bit                  used_plates [parking_pkg::plate_t];
    expected_t           expected_q [$];
    string               phase_q [$];
    string               phase = "reset";

    int credits = `QUEUE_DEPTH;
    int orders_sent = 0;
    int credits_back = 0;
    int max_outstanding = 0;
    int cycle_count = 0;

    parking_top UUT (
        .clock         (clock),
        .reset         (reset),
        .tick          (tick),
        .order_valid   (order_valid),
        .order_kind    (order_kind),
        .order_plate   (order_plate),
        .order_credit  (order_credit),
        .event_valid   (event_valid),
        .event_kind    (event_kind),
        .event_plate   (event_plate),
        .event_spot    (event_spot),
        .event_fee     (event_fee),
        .current_floor (current_floor)
    );

    bind parking_top parking_assertions bound_checks (
        .clock         (clock),
        .reset         (reset),
        .order_valid   (order_valid),
        .order_credit  (order_credit),
        .event_valid   (event_valid),
        .current_floor (current_floor)
    );

    always #2 clock = ~clock;

    task automatic stop_run(string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(string name, int expected, int actual);
        if (expected != actual) begin
            stop_run($sformatf("MISMATCH %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    task automatic step();
        @(posedge clock);
        #1;                     // Drive just after the edge
    endtask

    function automatic int rate_for(parking_pkg::plate_t plate);
        if (plate[`PLATE_W-1 -: 4] == 4'(`HANDICAP_NIBBLE)) return `RATE_HANDICAP;
        if (plate[`PLATE_W-1 -: 4] == 4'(`HYBRID_NIBBLE)) return `RATE_HYBRID;
        return `RATE_OTHER;
    endfunction

    // Odd plates on odd floors and the left spots of floors 1 and 2 for handicapped plates
    function automatic bit slot_allowed(parking_pkg::plate_t plate, int floor_no, int side);
        bit reserved;
        reserved = (side == 0) && (floor_no <= 2);
        return ((floor_no % 2) == int'(plate[0])) &&
               (!reserved || plate[`PLATE_W-1 -: 4] == 4'(`HANDICAP_NIBBLE));
    endfunction

    // Unique nonzero plate of type 0 handicapped, 1 hybrid or else ordinary
    function automatic parking_pkg::plate_t make_plate(int type_sel, logic suv);
        parking_pkg::plate_t p;
        do begin
            p = parking_pkg::plate_t'($urandom);
            case (type_sel)
                0:       p[`PLATE_W-1 -: 4] = 4'(`HANDICAP_NIBBLE);
                1:       p[`PLATE_W-1 -: 4] = 4'(`HYBRID_NIBBLE);
                default: p[`PLATE_W-1 -: 4] = 4'($urandom_range(7, 0));
            endcase
            p[0] = suv;
        end while (p == '0 || used_plates.exists(p));
        used_plates[p] = 1'b1;
        return p;
    endfunction

    function automatic void predict(parking_pkg::order_kind_t kind, parking_pkg::plate_t plate);
        expected_t exp;
        int        hit_floor;
        int        hit_side;
        logic      match;
        hit_floor = 0;
        hit_side  = 0;
        for (int f = 1; f <= `FLOORS; f++) begin
            for (int d = 0; d < 2; d++) begin
                match = (kind == parking_pkg::order_park) ?
                        (lot_plate[f][d] == '0 && slot_allowed(plate, f, d)) :
                        (lot_plate[f][d] == plate);
                if (hit_floor == 0 && match) begin
                    hit_floor = f;      // Lowest floor first and left before right
                    hit_side  = d;
                end
            end
        end
        exp.plate = plate;
        exp.spot  = '0;
        exp.fee   = '0;
        if (hit_floor == 0) begin
            exp.kind = parking_pkg::event_refused;
        end else begin
            exp.spot.floor = lot_pkg::floor_t'(hit_floor);
            exp.spot.side  = lot_pkg::side_t'(hit_side);
            if (kind == parking_pkg::order_park) begin
                exp.kind = parking_pkg::event_parked;
                lot_plate[hit_floor][hit_side] = plate;
                lot_fee[hit_floor][hit_side]   = 0;
            end else begin
                exp.kind = parking_pkg::event_departed;
                exp.fee  = parking_pkg::fee_t'(lot_fee[hit_floor][hit_side]);
                lot_plate[hit_floor][hit_side] = '0;
            end
        end
        expected_q.push_back(exp);
        phase_q.push_back(phase);
    endfunction

    task automatic send_order(parking_pkg::order_kind_t kind, parking_pkg::plate_t plate);
        while (credits == 0) step();    // Host holds off without a credit
        order_valid = 1'b1;
        order_kind  = kind;
        order_plate = plate;
        credits--;
        orders_sent++;
        if (`QUEUE_DEPTH - credits > max_outstanding) max_outstanding = `QUEUE_DEPTH - credits;
        predict(kind, plate);
        step();
        order_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (credits != `QUEUE_DEPTH || expected_q.size() != 0) step();
    endtask

    task automatic run_ticks(int count);
        repeat (count) begin
            tick = 1'b1;
            for (int f = 1; f <= `FLOORS; f++) begin
                for (int d = 0; d < 2; d++) begin
                    if (lot_plate[f][d] != '0) begin
                        lot_fee[f][d] = lot_fee[f][d] + rate_for(lot_plate[f][d]);
                        if (lot_fee[f][d] > `FEE_MAX) lot_fee[f][d] = `FEE_MAX;
                    end
                end
            end
            step();
            tick = 1'b0;
            step();
        end
    endtask

    // Retrieve every stride-th parked car in spot order
    task automatic retrieve_parked(int stride);
        parking_pkg::plate_t plates [$];
        int                  n;
        n = 0;
        for (int f = 1; f <= `FLOORS; f++) begin
            for (int d = 0; d < 2; d++) begin
                if (lot_plate[f][d] != '0) begin
                    if (n % stride == 0) plates.push_back(lot_plate[f][d]);
                    n++;
                end
            end
        end
        foreach (plates[i]) send_order(parking_pkg::order_retrieve, plates[i]);
    endtask

    // Credits and events sampled away from the driving edge
    always @(negedge clock) begin
        expected_t exp;
        string     name;
        if (!reset && order_credit) begin
            credits++;
            credits_back++;
            if (credits > `QUEUE_DEPTH) stop_run("Credit returned with no order outstanding");
        end
        if (!reset && event_valid) begin
            if (expected_q.size() == 0) begin
                stop_run("Event reported with no order outstanding");
            end else begin
                exp  = expected_q.pop_front();
                name = phase_q.pop_front();
                check_value({name, " event_kind"}, int'(exp.kind), int'(event_kind));
                check_value({name, " event_plate"}, int'(exp.plate), int'(event_plate));
                if (exp.kind != parking_pkg::event_refused) begin
                    check_value({name, " event_spot"}, int'(exp.spot), int'(event_spot));
                end
                if (exp.kind == parking_pkg::event_departed) begin
                    check_value({name, " event_fee"}, int'(exp.fee), int'(event_fee));
                end
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            stop_run($sformatf("Timeout, run not finished within %0d cycles", cycle_limit));
        end
    end

    initial begin
        void'($urandom(27338));
        for (int f = 1; f <= `FLOORS; f++) begin
            lot_plate[f][0] = '0;
            lot_plate[f][1] = '0;
        end
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;

        phase = "random parks";
        repeat (12) begin
            send_order(parking_pkg::order_park,
                       make_plate($urandom_range(2, 0), 1'($urandom_range(1, 0))));
        end
        wait_idle();

        phase = "short stay fees";
        run_ticks(7);
        retrieve_parked(2);
        wait_idle();

        phase = "freed spot reuse";
        for (int t = 0; t < 3; t++) begin
            send_order(parking_pkg::order_park, make_plate(t, 1'b0));
            send_order(parking_pkg::order_park, make_plate(t, 1'b1));
        end
        wait_idle();

        phase = "class overflow";
        repeat (8) send_order(parking_pkg::order_park, make_plate(2, 1'b1));
        repeat (6) send_order(parking_pkg::order_park, make_plate(2, 1'b0));
        send_order(parking_pkg::order_park, make_plate(0, 1'b0));
        send_order(parking_pkg::order_park, make_plate(0, 1'b1));
        send_order(parking_pkg::order_retrieve, make_plate(2, 1'b0));  // Never parked
        wait_idle();

        phase = "long stay fees";
        run_ticks(130);
        retrieve_parked(1);
        wait_idle();
        repeat (`FLOORS) step();        // Descent takes one cycle per floor

        check_value("elevator home", 0, int'(current_floor));
        check_value("credit per order", orders_sent, credits_back);
        check_value("full queue burst", `QUEUE_DEPTH, max_outstanding);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+source
source/parking_pkg.sv
source/lot_pkg.sv
source/parking_ifs.sv
source/order_queue.sv
source/slot_store.sv
source/fee_meter.sv
source/elevator_controller.sv
source/parking_top.sv
tb/parking_assertions.sv
tb/parking_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the parking tower testbench with Verilator, run it and check the log
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module parking_tb \
    --Mdir "$build_dir" -o parking_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/parking_sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Testbench passed" "$log_file"; then
    exit 0
fi
echo "Pass line missing from $log_file"
exit 1
